// ==== vector_alu.f ====
vec_types_pkg.sv
vec_ctrl_pkg.sv
vector_subtract.sv
vector_dot.sv
vec_op_dispatch.sv
vector_alu.sv
tb_clock_gen.sv
tb_vector_alu.sv

// ==== Makefile ====
# Verilator simulation of the vector ALU
TOP      ?= tb_vector_alu
FILELIST ?= vector_alu.f
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# run the testbench and pass only if the pass message shows up
sim:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_vector_alu.sv ====
`timescale 1ns/100ps

module tb_vector_alu #(
    parameter int TILING = 1
);

    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;

    localparam int NUM_ENTRIES = 12;
    localparam int N_STEPS     = VEC_LEN / TILING;
    localparam int LATENCY     = N_STEPS + 4;
    localparam int TIMEOUT     = NUM_ENTRIES * (N_STEPS + 4 + 3 + 4) + 50;
    localparam int CELL_MAX    = 2 ** (CELL_WIDTH - 1) - 1;
    localparam int CELL_MIN    = -(2 ** (CELL_WIDTH - 1));
    localparam int DOT_MAX     = 2 ** (DOT_WIDTH - 1) - 1;
    localparam int DOT_MIN     = -(2 ** (DOT_WIDTH - 1));

    typedef struct packed {
        vec_op_e    op;
        vec_t       a;
        vec_t       b;
        logic [1:0] hold;
        vec_rsp_t   exp;
    } test_entry_t;

    logic        clk;
    logic        rst;
    vec_cmd_t    cmd;
    logic        cmd_valid;
    logic        cmd_ready;
    vec_rsp_t    rsp;
    logic        rsp_valid;
    logic        rsp_ready;

    test_entry_t table_q [NUM_ENTRIES];
    int          error_count;
    int          cycle_count;

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    vector_alu #(
        .TILING (TILING)
    ) u_vector_alu (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    // expected response straight from the arithmetic rules
    function automatic vec_rsp_t model_response(vec_op_e op, vec_t a, vec_t b);
        vec_rsp_t r;
        cell_t    ca;
        cell_t    cb;
        int       d;
        int       s;
        int       i;
        r    = '0;
        r.op = op;
        s    = 0;
        for (i = 0; i < VEC_LEN; i++) begin
            ca = a[i*CELL_WIDTH +: CELL_WIDTH];
            cb = b[i*CELL_WIDTH +: CELL_WIDTH];
            if (op == OP_SUB) begin
                d = int'(ca) - int'(cb);
                if (d > CELL_MAX || d < CELL_MIN) r.error = 1'b1;
                r.diff[i*CELL_WIDTH +: CELL_WIDTH] = d[CELL_WIDTH-1:0];
            end else begin
                s = s + int'(ca) * int'(cb);
                if (s > DOT_MAX || s < DOT_MIN) r.error = 1'b1;
            end
        end
        if (op == OP_DOT) r.dot = s[DOT_WIDTH-1:0];
        return r;
    endfunction

    function automatic vec_t repeat_cell(int value);
        vec_t v;
        int   i;
        for (i = 0; i < VEC_LEN; i++) begin
            v[i*CELL_WIDTH +: CELL_WIDTH] = value[CELL_WIDTH-1:0];
        end
        return v;
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic build_table();
        logic [63:0] r64;
        int          i;
        // edge cases first, then random entries
        table_q[0] = '{OP_SUB, repeat_cell(-128), repeat_cell(1), 2'd0, '0};
        table_q[1] = '{OP_SUB, repeat_cell(127), repeat_cell(-1), 2'd3, '0};
        table_q[2] = '{OP_SUB, '0, '0, 2'd1, '0};
        table_q[3] = '{OP_DOT, repeat_cell(127), repeat_cell(127), 2'd2, '0};
        table_q[4] = '{OP_DOT, 40'h0504030201, 40'hFB04FD02FF, 2'd0, '0};
        for (i = 5; i < NUM_ENTRIES; i++) begin
            table_q[i].op   = vec_op_e'($urandom_range(1, 0));
            r64             = {$urandom(), $urandom()};
            table_q[i].a    = r64[VEC_LEN*CELL_WIDTH-1:0];
            r64             = {$urandom(), $urandom()};
            table_q[i].b    = r64[VEC_LEN*CELL_WIDTH-1:0];
            table_q[i].hold = 2'($urandom_range(3, 0));
        end
        for (i = 0; i < NUM_ENTRIES; i++) begin
            table_q[i].exp = model_response(table_q[i].op, table_q[i].a, table_q[i].b);
        end
    endtask

    task automatic run_entry(input test_entry_t e);
        int       latency;
        int       k;
        vec_rsp_t held;
        @(posedge clk);
        cmd.op    <= e.op;
        cmd.a     <= e.a;
        cmd.b     <= e.b;
        cmd_valid <= 1'b1;
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        // handshake seen, this is cycle 0
        @(posedge clk);
        cmd_valid <= 1'b0;
        cmd       <= '0;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
            if (!rsp_valid && cmd_ready) begin
                $display("ERROR at %0t: cmd_ready high while a command is in flight", $time);
                error_count++;
            end
        end while (!rsp_valid);
        compare("latency", 64'(LATENCY), 64'(latency));
        compare("rsp.op", 64'(e.exp.op), 64'(rsp.op));
        compare("rsp.diff", 64'(e.exp.diff), 64'(rsp.diff));
        compare("rsp.dot", 64'(e.exp.dot), 64'(rsp.dot));
        compare("rsp.error", 64'(e.exp.error), 64'(rsp.error));
        held = rsp;
        // back-pressure, response must sit still
        for (k = 0; k < int'(e.hold); k++) begin
            @(negedge clk);
            compare("rsp", 64'(held), 64'(rsp));
            compare("rsp_valid", 64'(1), 64'(rsp_valid));
            compare("cmd_ready", 64'(0), 64'(cmd_ready));
        end
        @(posedge clk);
        rsp_ready <= 1'b1;
        @(negedge clk);
        compare("rsp", 64'(held), 64'(rsp));
        compare("rsp_valid", 64'(1), 64'(rsp_valid));
        @(posedge clk);
        rsp_ready <= 1'b0;
        @(negedge clk);
        compare("rsp_valid", 64'(0), 64'(rsp_valid));
        compare("cmd_ready", 64'(1), 64'(cmd_ready));
    endtask

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("run did not finish within %0d cycles, giving up", TIMEOUT);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        cmd         = '0;
        cmd_valid   = 1'b0;
        rsp_ready   = 1'b0;
        error_count = 0;
        cycle_count = 0;
        void'($urandom(62));
        build_table();

        @(negedge clk);
        while (rst) @(negedge clk);
        compare("cmd_ready", 64'(1), 64'(cmd_ready));
        compare("rsp_valid", 64'(0), 64'(rsp_valid));

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(table_q[i]);
        end

        $display("checks done, %0d errors", error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== vector_alu.sv ====
`timescale 1ns/100ps

module vector_alu #(
    parameter int TILING = 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  vec_ctrl_pkg::vec_cmd_t cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    output vec_ctrl_pkg::vec_rsp_t rsp,
    output logic                   rsp_valid,
    input  logic                   rsp_ready
);

    import vec_types_pkg::*;

    vec_t sub_a;
    vec_t sub_b;
    logic sub_valid;
    vec_t sub_result;
    logic sub_result_valid;
    logic sub_result_ready;
    logic sub_error;

    vec_t dot_a;
    vec_t dot_b;
    logic dot_valid;
    dot_t dot_sum;
    logic dot_result_valid;
    logic dot_result_ready;
    logic dot_error;

    vec_op_dispatch u_dispatch (
        .clk              (clk),
        .rst              (rst),
        .cmd              (cmd),
        .cmd_valid        (cmd_valid),
        .cmd_ready        (cmd_ready),
        .rsp              (rsp),
        .rsp_valid        (rsp_valid),
        .rsp_ready        (rsp_ready),
        .sub_a            (sub_a),
        .sub_b            (sub_b),
        .sub_valid        (sub_valid),
        .sub_result       (sub_result),
        .sub_result_valid (sub_result_valid),
        .sub_error        (sub_error),
        .sub_result_ready (sub_result_ready),
        .dot_a            (dot_a),
        .dot_b            (dot_b),
        .dot_valid        (dot_valid),
        .dot_sum          (dot_sum),
        .dot_result_valid (dot_result_valid),
        .dot_error        (dot_error),
        .dot_result_ready (dot_result_ready)
    );

    // ready outputs unused, dispatcher only issues to an idle unit
    vector_subtract #(
        .TILING (TILING)
    ) u_subtract (
        .clk          (clk),
        .rst          (rst),
        .a            (sub_a),
        .a_valid      (sub_valid),
        .a_ready      (),
        .b            (sub_b),
        .b_valid      (sub_valid),
        .b_ready      (),
        .result       (sub_result),
        .result_valid (sub_result_valid),
        .result_ready (sub_result_ready),
        .error        (sub_error)
    );

    vector_dot #(
        .TILING (TILING)
    ) u_dot (
        .clk          (clk),
        .rst          (rst),
        .a            (dot_a),
        .a_valid      (dot_valid),
        .a_ready      (),
        .b            (dot_b),
        .b_valid      (dot_valid),
        .b_ready      (),
        .sum          (dot_sum),
        .result_valid (dot_result_valid),
        .result_ready (dot_result_ready),
        .error        (dot_error)
    );

endmodule

// ==== vec_op_dispatch.sv ====
`timescale 1ns/100ps

module vec_op_dispatch (
    input  logic                   clk,
    input  logic                   rst,
    // command channel
    input  vec_ctrl_pkg::vec_cmd_t cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    // response channel
    output vec_ctrl_pkg::vec_rsp_t rsp,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    // subtract unit
    output vec_types_pkg::vec_t    sub_a,
    output vec_types_pkg::vec_t    sub_b,
    output logic                   sub_valid,
    input  vec_types_pkg::vec_t    sub_result,
    input  logic                   sub_result_valid,
    input  logic                   sub_error,
    output logic                   sub_result_ready,
    // dot unit
    output vec_types_pkg::vec_t    dot_a,
    output vec_types_pkg::vec_t    dot_b,
    output logic                   dot_valid,
    input  vec_types_pkg::dot_t    dot_sum,
    input  logic                   dot_result_valid,
    input  logic                   dot_error,
    output logic                   dot_result_ready
);

    import vec_ctrl_pkg::*;

    typedef enum logic [1:0] {
        ACCEPT  = 2'd0,
        ISSUE   = 2'd1,
        WAIT    = 2'd2,
        RESPOND = 2'd3
    } disp_state_e;

    disp_state_e state;
    vec_cmd_t    cmd_q;
    vec_rsp_t    rsp_q;
    logic        sub_valid_q;
    logic        dot_valid_q;
    logic        sel_sub;
    logic        sel_result_valid;

    assign sel_sub          = (cmd_q.op == OP_SUB);
    assign sel_result_valid = sel_sub ? sub_result_valid : dot_result_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ACCEPT;
            sub_valid_q <= 1'b0;
            dot_valid_q <= 1'b0;
        end else begin
            case (state)
                ACCEPT: begin
                    if (cmd_valid) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    // one-cycle pulse to the chosen unit
                    sub_valid_q <= sel_sub;
                    dot_valid_q <= !sel_sub;
                    state       <= WAIT;
                end
                WAIT: begin
                    sub_valid_q <= 1'b0;
                    dot_valid_q <= 1'b0;
                    if (sel_result_valid) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (rsp_ready) begin
                        state <= ACCEPT;
                    end
                end
                default: state <= ACCEPT;
            endcase
        end
    end

    // command latch and response capture
    always_ff @(posedge clk) begin
        if (state == ACCEPT && cmd_valid) begin
            cmd_q <= cmd;
        end
        if (state == WAIT && sel_result_valid) begin
            rsp_q.op    <= cmd_q.op;
            rsp_q.diff  <= sel_sub ? sub_result : '0;
            rsp_q.dot   <= sel_sub ? '0 : dot_sum;
            rsp_q.error <= sel_sub ? sub_error : dot_error;
        end
    end

    assign cmd_ready = (state == ACCEPT);
    assign rsp_valid = (state == RESPOND);
    assign rsp       = rsp_q;

    assign sub_a            = cmd_q.a;
    assign sub_b            = cmd_q.b;
    assign sub_valid        = sub_valid_q;
    assign sub_result_ready = (state == WAIT) && sel_sub;

    assign dot_a            = cmd_q.a;
    assign dot_b            = cmd_q.b;
    assign dot_valid        = dot_valid_q;
    assign dot_result_ready = (state == WAIT) && !sel_sub;

    // units only finish while a command is outstanding
    a_result_in_wait: assert property (@(posedge clk) disable iff (rst)
        (sub_result_valid || dot_result_valid) |-> (state == WAIT))
        else $error("unit result_valid seen outside WAIT");

endmodule

// ==== vector_dot.sv ====
`timescale 1ns/100ps

module vector_dot #(
    parameter int TILING = 1
) (
    input  logic                clk,
    input  logic                rst,
    input  vec_types_pkg::vec_t a,
    input  logic                a_valid,
    output logic                a_ready,
    input  vec_types_pkg::vec_t b,
    input  logic                b_valid,
    output logic                b_ready,
    output vec_types_pkg::dot_t sum,
    output logic                result_valid,
    input  logic                result_ready,
    output logic                error
);

    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;

    localparam int CNT_W = $clog2(VEC_LEN + 1);

    unit_state_e       state;
    logic [CNT_W-1:0]  cnt;
    vec_t              a_q;
    vec_t              b_q;
    dot_t              acc_q;
    logic              error_q;
    logic              start;

    dot_t              partial [TILING+1];
    logic [TILING-1:0] add_ovf;

    assign start = a_valid && b_valid;

    // first CALC cycle starts from zero
    assign partial[0] = (cnt == '0) ? '0 : acc_q;

    // chained MAC lanes with an overflow check per addition
    for (genvar i = 0; i < TILING; i++) begin : g_mac
        logic signed [2*CELL_WIDTH-1:0] prod;
        dot_t                           prod_ext;

        assign prod = $signed(a_q[(cnt + i) * CELL_WIDTH +: CELL_WIDTH])
                    * $signed(b_q[(cnt + i) * CELL_WIDTH +: CELL_WIDTH]);
        assign prod_ext = dot_t'(prod);
        assign partial[i+1] = partial[i] + prod_ext;
        assign add_ovf[i] = (partial[i][DOT_WIDTH-1] == prod_ext[DOT_WIDTH-1])
                         && (partial[i+1][DOT_WIDTH-1] != partial[i][DOT_WIDTH-1]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            cnt     <= '0;
            acc_q   <= '0;
            error_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (start) begin
                        state   <= CALC;
                        error_q <= 1'b0;
                    end
                end
                CALC: begin
                    cnt     <= cnt + CNT_W'(TILING);
                    acc_q   <= partial[TILING];
                    error_q <= error_q | (|add_ovf);
                    if (cnt == CNT_W'(VEC_LEN - TILING)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (result_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            a_q <= a;
            b_q <= b;
        end
    end

    assign a_ready      = (state == IDLE);
    assign b_ready      = (state == IDLE);
    assign sum          = acc_q;
    assign result_valid = (state == DONE);
    assign error        = error_q;

    // operands only arrive while the unit is idle
    a_valid_only_in_idle: assert property (@(posedge clk) disable iff (rst)
        (a_valid || b_valid) |-> (state == IDLE))
        else $error("dot operands offered outside IDLE");

endmodule

// ==== vector_subtract.sv ====
`timescale 1ns/100ps

module vector_subtract #(
    parameter int TILING = 1
) (
    input  logic                clk,
    input  logic                rst,
    input  vec_types_pkg::vec_t a,
    input  logic                a_valid,
    output logic                a_ready,
    input  vec_types_pkg::vec_t b,
    input  logic                b_valid,
    output logic                b_ready,
    output vec_types_pkg::vec_t result,
    output logic                result_valid,
    input  logic                result_ready,
    output logic                error
);

    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;

    localparam int CNT_W = $clog2(VEC_LEN + 1);

    unit_state_e       state;
    logic [CNT_W-1:0]  cnt;
    vec_t              a_q;
    vec_t              b_q;
    vec_t              result_q;
    logic              error_q;
    logic              start;

    cell_t             tile_diff [TILING];
    logic [TILING-1:0] tile_ovf;

    assign start = a_valid && b_valid;

    // one subtractor per lane, one extra bit to catch wrap
    for (genvar i = 0; i < TILING; i++) begin : g_lane
        logic signed [CELL_WIDTH:0] wide;

        assign wide = $signed(a_q[(cnt + i) * CELL_WIDTH +: CELL_WIDTH])
                    - $signed(b_q[(cnt + i) * CELL_WIDTH +: CELL_WIDTH]);
        assign tile_diff[i] = wide[CELL_WIDTH-1:0];
        // extended sign disagrees with cell sign on over- or underflow
        assign tile_ovf[i] = wide[CELL_WIDTH] ^ wide[CELL_WIDTH-1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            cnt     <= '0;
            error_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (start) begin
                        state   <= CALC;
                        error_q <= 1'b0;
                    end
                end
                CALC: begin
                    cnt     <= cnt + CNT_W'(TILING);
                    error_q <= error_q | (|tile_ovf);
                    if (cnt == CNT_W'(VEC_LEN - TILING)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (result_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // operand and result registers
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            a_q <= a;
            b_q <= b;
        end
        if (state == CALC) begin
            for (int i = 0; i < TILING; i++) begin
                result_q[(cnt + i) * CELL_WIDTH +: CELL_WIDTH] <= tile_diff[i];
            end
        end
    end

    assign a_ready      = (state == IDLE);
    assign b_ready      = (state == IDLE);
    assign result       = result_q;
    assign result_valid = (state == DONE);
    assign error        = error_q;

    a_tiling_divides: assert property (@(posedge clk) (VEC_LEN % TILING) == 0)
        else $error("TILING %0d does not divide VEC_LEN %0d", TILING, VEC_LEN);

    // operands arrive as a pair
    a_operands_paired: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE) |-> (a_valid == b_valid))
        else $error("a_valid and b_valid differ in IDLE");

endmodule

// ==== vec_ctrl_pkg.sv ====
package vec_ctrl_pkg;

    typedef enum logic {
        OP_SUB = 1'b0,
        OP_DOT = 1'b1
    } vec_op_e;

    typedef struct packed {
        vec_op_e             op;
        vec_types_pkg::vec_t a;
        vec_types_pkg::vec_t b;
    } vec_cmd_t;

    // only the field matching op carries data, the other reads zero
    typedef struct packed {
        vec_op_e             op;
        vec_types_pkg::vec_t diff;
        vec_types_pkg::dot_t dot;
        logic                error;
    } vec_rsp_t;

    // shared by both compute units
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        CALC = 2'd1,
        DONE = 2'd2
    } unit_state_e;

endpackage

// ==== vec_types_pkg.sv ====
package vec_types_pkg;

    // cells per vector
    localparam int VEC_LEN = 5;

    // bits per signed cell
    localparam int CELL_WIDTH = 8;

    // dot product accumulator width
    localparam int DOT_WIDTH = 16;

    // one signed cell
    typedef logic signed [CELL_WIDTH-1:0] cell_t;

    // cell 0 sits in the low bits
    typedef logic [VEC_LEN*CELL_WIDTH-1:0] vec_t;

    // signed dot product sum
    typedef logic signed [DOT_WIDTH-1:0] dot_t;

endpackage
